// ==== Bender.yml ====
package:
  name: uart_bridge

sources:
  - files:
      - uart_pkg.sv
      - uart_rx.sv
      - uart_tx.sv
      - cmd_sequencer.sv
      - uart.sv
  - target: simulation
    files:
      - uart_asserts.sv
      - tb_uart.sv

// ==== cmd_sequencer.sv ====
module cmd_sequencer
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output logic                  tx_start,
  output logic [DATA_WIDTH-1:0] tx_data,
  input  logic                  tx_busy,
  input  logic [DATA_WIDTH-1:0] rx_data,
  input  logic                  rx_valid,
  input  logic                  rx_err,
  input  logic                  rx_start_seen,
  output logic [DATA_WIDTH-1:0] read_data,
  output logic                  read_rdy,
  output logic                  read_err
);

  localparam int GAP_CYC = GAP_BITS * CLKS_PER_BIT;
  localparam int TMO_CYC = RX_TIMEOUT_BITS * CLKS_PER_BIT;
  localparam int TMR_W   = $clog2(TMO_CYC + 1);

  seq_state_t           state;
  seq_state_t           state_nxt;
  logic [CMD_WIDTH-1:0] cmd_buf;
  logic [TMR_W-1:0]     timer;     // Shared by gap and reply timeout
  logic                 start_seen;
  logic                 gap_done;
  logic                 tmo_done;

  assign gap_done = (timer == TMR_W'(GAP_CYC - 1));
  assign tmo_done = !start_seen && !rx_start_seen && (timer == TMR_W'(TMO_CYC - 1));

  // --------------------------------------------------------------------------
  // State machine
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state <= IDLE;
    else state <= state_nxt;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:        if (cmd_vld) state_nxt = RW_JUDGE;
      RW_JUDGE:    state_nxt = cmd_buf[WRITE_BIT] ? W_HIGH_BYTE : R_CMD_BYTE;
      W_HIGH_BYTE: if (!tx_busy) state_nxt = W_DELAY;
      W_DELAY:     if (gap_done) state_nxt = W_LOW_BYTE;
      W_LOW_BYTE:  if (!tx_busy) state_nxt = IDLE;
      R_CMD_BYTE:  if (!tx_busy) state_nxt = R_DELAY;
      R_DELAY:     if (gap_done) state_nxt = R_WAIT_DATA;
      R_WAIT_DATA: begin
        if (start_seen) begin
          if (rx_valid) state_nxt = SEND_READ_DATA;
          else if (rx_err) state_nxt = IDLE;
        end else if (tmo_done) begin
          state_nxt = IDLE;
        end
      end
      SEND_READ_DATA: state_nxt = IDLE;
      default:        state_nxt = IDLE;
    endcase
  end

  // Gap and timeout counter, restarts on every state change
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timer      <= '0;
      start_seen <= 1'b0;
    end else begin
      if (state_nxt != state)
        timer <= '0;
      else if ((state == W_DELAY) || (state == R_DELAY) ||
               ((state == R_WAIT_DATA) && !start_seen))
        timer <= timer + 1'b1;

      if (state != R_WAIT_DATA) start_seen <= 1'b0;
      else if (rx_start_seen) start_seen <= 1'b1;  // Stops the timeout
    end
  end

  // --------------------------------------------------------------------------
  // Command and reply data
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if ((state == IDLE) && cmd_vld) cmd_buf <= cmd_in;
    if ((state == R_WAIT_DATA) && start_seen && rx_valid) read_data <= rx_data;
  end

  assign cmd_rdy  = (state == IDLE);
  assign tx_start = (state == RW_JUDGE) || ((state == W_DELAY) && gap_done);
  assign tx_data  = (state == RW_JUDGE) ? cmd_buf[CMD_WIDTH-1:DATA_WIDTH]
                                        : cmd_buf[DATA_WIDTH-1:0];
  assign read_rdy = (state == SEND_READ_DATA);
  assign read_err = (state == R_WAIT_DATA) && ((start_seen && rx_err) || tmo_done);

endmodule

// ==== tb.f ====
uart_pkg.sv
uart_rx.sv
uart_tx.sv
cmd_sequencer.sv
uart.sv
uart_asserts.sv
tb_uart.sv

// ==== tb_uart.sv ====
module tb_uart
  import uart_pkg::*;
();

  localparam int CPB       = 8;
  localparam int FRAME_CYC = 11 * CPB;
  localparam int LIMIT     = 2000;  // Cycles per wait
  localparam int GOOD = 0, BAD_PAR = 1, BAD_STOP = 2, SILENT = 3;
  localparam int ON_RDY = 0, ON_FRAMES = 1, ON_CYCLE = 2, ON_RESULT = 3;

  logic                  clk, rst_n, cmd_vld, rx;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  tx, read_rdy, cmd_rdy, read_err;
  logic [DATA_WIDTH-1:0] read_data, last_read;
  logic [DATA_WIDTH-1:0] exp_bytes[$];
  bit                    exp_gap[$];  // Frame must follow an idle gap
  int seed, errors = 0, timeouts = 0, cycle = 0, accept_cyc = 0;
  int last_start = 0, frames = 0, rdy_cnt = 0, err_cnt = 0, err_cyc = 0;

  uart #(.CLKS_PER_BIT(CPB)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  always @(negedge clk) begin
    if (read_rdy) begin
      rdy_cnt++;
      last_read = read_data;
    end
    if (read_err) begin
      err_cnt++;
      err_cyc = cycle;
    end
  end

  function automatic logic even_parity(input logic [DATA_WIDTH-1:0] b);
    logic p;
    p = 1'b0;
    for (int i = 0; i < DATA_WIDTH; i++) p = p ^ b[i];
    return p;
  endfunction

  function automatic bit cond_met(input int kind, input int arg);
    case (kind)
      ON_RDY:    return cmd_rdy;
      ON_FRAMES: return frames >= arg;
      ON_CYCLE:  return cycle >= arg;
      default:   return (rdy_cnt + err_cnt) >= arg;
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  task automatic wait_for(input int kind, input int arg, input string what);
    int t;
    t = 0;
    while (!cond_met(kind, arg) && t < LIMIT) begin
      @(posedge clk);
      #2;
      t++;
    end
    if (!cond_met(kind, arg)) begin
      timeouts++;
      $display("Timeout at %0t while waiting for %s", $time, what);
    end
  endtask

  // --------------------------------------------------------------------------
  // Serial line model
  // --------------------------------------------------------------------------
  initial begin : tx_monitor
    logic [10:0]           fr;
    logic                  prev;
    logic [DATA_WIDTH-1:0] exp;
    bit                    gap;
    int                    start, prev_end;
    prev = 1'b1;
    prev_end = 0;
    forever begin
      @(negedge clk);
      if (rst_n && prev && !tx) begin
        start = cycle;
        repeat (CPB / 2) @(negedge clk);  // Middle of start bit
        fr[0] = tx;
        for (int k = 1; k < 11; k++) begin
          repeat (CPB) @(negedge clk);
          fr[k] = tx;
        end
        assert (fr[0] == 1'b0 && fr[10] == 1'b1)
          else report_mismatch($sformatf("start bit %b stop bit %b", fr[0], fr[10]));
        assert (fr[9] == even_parity(fr[8:1]))
          else report_mismatch($sformatf("parity %b for byte %h", fr[9], fr[8:1]));
        if (exp_bytes.size() == 0) begin
          errors++;
          $display("Unexpected frame on tx at %0t with no command pending", $time);
        end else begin
          exp = exp_bytes.pop_front();
          gap = exp_gap.pop_front();
          assert (fr[8:1] == exp)
            else report_mismatch($sformatf("tx byte %h expected %h", fr[8:1], exp));
          if (gap) begin
            assert (start - prev_end >= GAP_BITS * CPB)
              else report_mismatch($sformatf("gap of %0d cycles", start - prev_end));
          end else begin
            assert (start - accept_cyc <= 3)
              else report_mismatch($sformatf("start bit %0d cycles late", start - accept_cyc));
          end
        end
        prev_end   = start + FRAME_CYC;
        last_start = start;
        frames++;
      end
      prev = tx;
    end
  end

  task automatic drive_reply(input logic [DATA_WIDTH-1:0] b, input logic bad_par,
                             input logic bad_stop);
    logic [10:0] fr;
    fr = {~bad_stop, even_parity(b) ^ bad_par, b, 1'b0};
    for (int k = 0; k < 11; k++) begin
      rx = fr[k];
      repeat (CPB) @(posedge clk);
      #2;
    end
    rx = 1'b1;
  endtask

  // --------------------------------------------------------------------------
  // Host side
  // --------------------------------------------------------------------------
  task automatic issue_cmd(input logic [CMD_WIDTH-1:0] cmd);
    wait_for(ON_RDY, 0, "cmd_rdy before command");
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    exp_bytes.push_back(cmd[CMD_WIDTH-1:DATA_WIDTH]);
    exp_gap.push_back(1'b0);
    if (cmd[WRITE_BIT]) begin
      exp_bytes.push_back(cmd[DATA_WIDTH-1:0]);
      exp_gap.push_back(1'b1);
    end
    @(posedge clk);
    #2;
    accept_cyc = cycle;
    cmd_vld    = 1'b0;
  endtask

  // Strobe that must be ignored
  task automatic poke_busy(input logic [CMD_WIDTH-1:0] junk);
    repeat (25) @(posedge clk);
    #2;
    if (!cmd_rdy) begin
      cmd_in  = junk;
      cmd_vld = 1'b1;
      @(posedge clk);
      #2;
      cmd_vld = 1'b0;
    end
  endtask

  task automatic run_cmd(input logic [CMD_WIDTH-1:0] cmd, input int mode, input int pokes);
    int                    r0, e0, n0, stop_end;
    logic [DATA_WIDTH-1:0] reply;
    r0    = rdy_cnt;
    e0    = err_cnt;
    n0    = frames;
    reply = DATA_WIDTH'($random(seed));
    issue_cmd(cmd);
    repeat (pokes) poke_busy(CMD_WIDTH'($random(seed)));
    if (cmd[WRITE_BIT]) begin
      wait_for(ON_FRAMES, n0 + 2, "both write frames");
      wait_for(ON_RDY, 0, "cmd_rdy after write");
      assert (cycle >= last_start + FRAME_CYC) else report_mismatch("cmd_rdy before stop end");
      assert (rdy_cnt == r0 && err_cnt == e0) else report_mismatch("read pulse during write");
    end else begin
      wait_for(ON_FRAMES, n0 + 1, "read command frame");
      stop_end = last_start + FRAME_CYC;
      if (mode != SILENT) begin
        wait_for(ON_CYCLE, stop_end + (GAP_BITS + 1) * CPB, "reply slot");
        drive_reply(reply, mode == BAD_PAR, mode == BAD_STOP);
      end
      wait_for(ON_RESULT, r0 + e0 + 1, "read result pulse");
      wait_for(ON_RDY, 0, "cmd_rdy after read");
      if (mode == GOOD) begin
        assert (rdy_cnt == r0 + 1 && err_cnt == e0)
          else report_mismatch($sformatf("%0d read_rdy %0d read_err", rdy_cnt - r0, err_cnt - e0));
        assert (last_read == reply)
          else report_mismatch($sformatf("read_data %h expected %h", last_read, reply));
      end else begin
        assert (err_cnt == e0 + 1 && rdy_cnt == r0)
          else report_mismatch($sformatf("%0d read_rdy %0d read_err", rdy_cnt - r0, err_cnt - e0));
      end
      if (mode == SILENT) begin
        assert (err_cyc - stop_end <= (RX_TIMEOUT_BITS + GAP_BITS + 2) * CPB)
          else report_mismatch($sformatf("timeout after %0d cycles", err_cyc - stop_end));
      end
    end
  endtask

  initial begin : stimulus
    int fails;
    seed    = 32'h7dd92ddf;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    assert (tx && cmd_rdy && !read_rdy && !read_err) else report_mismatch("outputs after reset");
    @(posedge clk);
    #2;
    repeat (4) run_cmd(CMD_WIDTH'($random(seed)) | 16'h8000, GOOD, 0);
    repeat (4) run_cmd(CMD_WIDTH'($random(seed)) & 16'h7fff, GOOD, 0);
    run_cmd(CMD_WIDTH'($random(seed)) & 16'h7fff, BAD_PAR, 0);
    run_cmd(CMD_WIDTH'($random(seed)) & 16'h7fff, BAD_STOP, 0);
    run_cmd(CMD_WIDTH'($random(seed)) & 16'h7fff, SILENT, 0);
    run_cmd(CMD_WIDTH'($random(seed)) | 16'h8000, GOOD, 3);  // Strobes while busy
    run_cmd(CMD_WIDTH'($random(seed)) & 16'h7fff, GOOD, 2);
    run_cmd(CMD_WIDTH'($random(seed)) | 16'h8000, GOOD, 0);
    repeat (4 * FRAME_CYC) @(posedge clk);  // Room for any stray frame
    assert (exp_bytes.size() == 0) else report_mismatch("expected frames never appeared");
    fails = dut0.u_asserts.fail_cnt;
    $display("Summary: %0d check errors, %0d timeouts, %0d assertion failures",
             errors, timeouts, fails);
    if (errors + timeouts + fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== uart.sv ====
module uart
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  input  logic                  rx,
  output logic                  tx,
  output logic                  read_rdy,
  output logic [DATA_WIDTH-1:0] read_data,
  output logic                  cmd_rdy,
  output logic                  read_err
);

  logic                  tx_start;
  logic [DATA_WIDTH-1:0] tx_data;
  logic                  tx_busy;
  logic [DATA_WIDTH-1:0] rx_data;
  logic                  rx_valid;
  logic                  rx_err;
  logic                  rx_start_seen;

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .rx_err        (rx_err),
    .rx_start_seen (rx_start_seen)
  );

  cmd_sequencer #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_data       (tx_data),
    .tx_busy       (tx_busy),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .rx_err        (rx_err),
    .rx_start_seen (rx_start_seen),
    .read_data     (read_data),
    .read_rdy      (read_rdy),
    .read_err      (read_err)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

endmodule

// ==== uart_asserts.sv ====
module uart_asserts (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic read_rdy,
  input logic read_err
);

  int fail_cnt = 0;

  // Line idles high while waiting for a command
  a_idle_line: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else begin
      $error("tx low while cmd_rdy is high");
      fail_cnt++;
    end

  a_one_result: assert property (@(posedge clk) disable iff (!rst_n) !(read_rdy && read_err))
    else begin
      $error("read_rdy and read_err high together");
      fail_cnt++;
    end

  a_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else begin
      $error("read_rdy longer than one cycle");
      fail_cnt++;
    end

  a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_err |=> !read_err)
    else begin
      $error("read_err longer than one cycle");
      fail_cnt++;
    end

  a_accept: assert property (@(posedge clk) disable iff (!rst_n)
                             cmd_vld && cmd_rdy |=> !cmd_rdy)
    else begin
      $error("cmd_rdy still high after an accepted command");
      fail_cnt++;
    end

endmodule

bind uart uart_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy),
  .read_err (read_err)
);

// ==== uart_pkg.sv ====
package uart_pkg;

  // --------------------------------------------------------------------------
  // Frame and command format
  // --------------------------------------------------------------------------
  localparam int CMD_WIDTH  = 16;
  localparam int DATA_WIDTH = 8;
  localparam int WRITE_BIT  = 15;  // 1 selects write, 0 read

  localparam int GAP_BITS        = 2;   // Idle bit periods between frames
  localparam int RX_TIMEOUT_BITS = 32;  // Reply start bit must arrive by then

  // --------------------------------------------------------------------------
  // Sequencer states
  // --------------------------------------------------------------------------
  typedef enum logic [3:0] {
    IDLE,
    RW_JUDGE,
    W_HIGH_BYTE,
    W_DELAY,
    W_LOW_BYTE,
    R_CMD_BYTE,
    R_DELAY,
    R_WAIT_DATA,
    SEND_READ_DATA
  } seq_state_t;

endpackage

// ==== uart_rx.sv ====
module uart_rx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rx,
  output logic [DATA_WIDTH-1:0] rx_data,
  output logic                  rx_valid,
  output logic                  rx_err,
  output logic                  rx_start_seen
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [3:0] PAR_IDX  = 4'(DATA_WIDTH + 1);
  localparam logic [3:0] STOP_IDX = 4'(DATA_WIDTH + 2);

  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic                  busy;
  logic [CNT_W-1:0]      os_cnt;
  logic [3:0]            bit_idx;   // 0 start, then data, parity, stop
  logic [DATA_WIDTH-1:0] data_sr;
  logic                  par_bit;
  logic                  half_pt;
  logic                  bit_end;

  assign half_pt = (os_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
  assign bit_end = (os_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign rx_data = data_sr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;  // For falling edge detect
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy          <= 1'b0;
      os_cnt        <= '0;
      bit_idx       <= '0;
      rx_valid      <= 1'b0;
      rx_err        <= 1'b0;
      rx_start_seen <= 1'b0;
    end else begin
      rx_valid      <= 1'b0;
      rx_err        <= 1'b0;
      rx_start_seen <= 1'b0;
      if (!busy) begin
        os_cnt  <= '0;
        bit_idx <= '0;
        if (rx_prev && !rx_sync) busy <= 1'b1;
      end else if (bit_idx == 4'd0) begin
        if (half_pt) begin
          os_cnt <= '0;
          if (!rx_sync) begin
            rx_start_seen <= 1'b1;
            bit_idx       <= 4'd1;
          end else begin
            busy <= 1'b0;  // Glitch, back to idle
          end
        end else begin
          os_cnt <= os_cnt + 1'b1;
        end
      end else if (bit_end) begin
        os_cnt  <= '0;
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == STOP_IDX) begin
          busy <= 1'b0;
          if (rx_sync && (par_bit == ^data_sr)) rx_valid <= 1'b1;
          else rx_err <= 1'b1;
        end
      end else begin
        os_cnt <= os_cnt + 1'b1;
      end
    end
  end

  // Sampled payload
  always_ff @(posedge clk) begin
    if (busy && bit_end && (bit_idx != 4'd0) && (bit_idx < PAR_IDX))
      data_sr <= {rx_sync, data_sr[DATA_WIDTH-1:1]};  // LSB arrives first
    if (busy && bit_end && (bit_idx == PAR_IDX))
      par_bit <= rx_sync;
  end

endmodule

// ==== uart_tx.sv ====
module uart_tx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  tx_start,
  input  logic [DATA_WIDTH-1:0] tx_data,
  output logic                  tx,
  output logic                  tx_busy
);

  localparam int CNT_W   = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int FRAME_W = DATA_WIDTH + 3;  // Start, data, parity, stop

  logic [FRAME_W-1:0] frame;
  logic [CNT_W-1:0]   clk_cnt;
  logic [3:0]         bit_idx;
  logic               bit_end;

  assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  // --------------------------------------------------------------------------
  // Bit timing and line driver
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else if (!tx_busy) begin
      clk_cnt <= '0;
      bit_idx <= '0;
      if (tx_start) begin
        tx      <= 1'b0;  // Start bit
        tx_busy <= 1'b1;
      end
    end else if (bit_end) begin
      clk_cnt <= '0;
      if (bit_idx == 4'(FRAME_W - 1)) begin
        tx      <= 1'b1;  // Stop bit done
        tx_busy <= 1'b0;
      end else begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= frame[1];
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // Frame shift register
  always_ff @(posedge clk) begin
    if (tx_start && !tx_busy)
      frame <= {1'b1, ^tx_data, tx_data, 1'b0};  // Even parity
    else if (tx_busy && bit_end)
      frame <= frame >> 1;
  end

endmodule
